/* nspc_top.f */
+incdir+include
src/nspc_pkg.sv
src/nspc_weight_regs.sv
src/nspc_bundle_pe.sv
src/nspc_accum_stage.sv
src/nspc_top.sv
test/nspc_assertions.sv
test/nspc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= nspc_tb
FILELIST  ?= nspc_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/nspc_tb.sv */
`timescale 1ns/1ps

`include "nspc_cfg.svh"

module nspc_tb;

   localparam int STREAM_LEN = 40;

   // packed {sign, n3, n2} codes, kernel 0 first
   localparam logic [7:0] REF_TABLE [`NSPC_NUM_WEIGHT] = '{
      8'h11, 8'h8A, 8'h18, 8'h02, 8'h92, 8'h09, 8'h81, 8'h22,
      8'h0A, 8'h99, 8'h12, 8'h88, 8'h19, 8'h01, 8'h91, 8'h13
   };

   logic                                clk;
   logic                                rst_n;
   logic                                in_valid;
   logic                                in_ready;
   logic [`NSPC_NUM_IN*`NSPC_ACT_W-1:0] in_data;
   logic                                out_valid;
   logic                                out_ready;
   logic [`NSPC_OUT_W-1:0]              out_y0;
   logic [`NSPC_OUT_W-1:0]              out_y1;
   logic                                cfg_valid;
   logic [`NSPC_CFG_AW-1:0]             cfg_addr;
   logic [7:0]                          cfg_data;

   integer      seed;
   int          timeouts;
   int          tests_run;
   int          total_fail;
   int          chk_mark;
   int          timeout_mark;
   logic [31:0] stim_q[$];

   nspc_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_y0    (out_y0),
      .out_y1    (out_y1),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data)
   );

   bind nspc_top nspc_assertions u_chk (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .in_data   (in_data),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_y0    (out_y0),
      .out_y1    (out_y1),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data)
   );

   always #2 clk = ~clk;

   // ********************
   // helpers
   // ********************
   task automatic note_timeout(input string what);
      $display("timeout at %0t while waiting for %s", $time, what);
      timeouts++;
   endtask

   // called and returns just after a falling edge
   task automatic cfg_write(input int addr, input logic [7:0] data);
      cfg_valid = 1'b1;
      cfg_addr  = `NSPC_CFG_AW'(addr);
      cfg_data  = data;
      @(negedge clk);
      cfg_valid = 1'b0;
   endtask

   task automatic set_weight(input int k, input int i, input bit neg, input int n3,
                             input int n2);
      cfg_write(k * `NSPC_NUM_IN + i, {neg, 4'(n3), 3'(n2)});
   endtask

   // reserved bits are set to show they are dropped
   task automatic set_shift(input int k, input int b, input int amount);
      cfg_write(`NSPC_SHIFT_BASE + k * `NSPC_NUM_BUNDLE + b, {6'b101101, 2'(amount)});
   endtask

   task automatic load_table(input logic [7:0] table_in [`NSPC_NUM_WEIGHT]);
      int w;
      for (w = 0; w < `NSPC_NUM_WEIGHT; w++) begin
         cfg_write(w, table_in[w]);
      end
   endtask

   // one process pushes the stim_q words and drains their results
   task automatic stream_words(input int stall_pct);
      int  sent;
      int  received;
      int  cycles;
      int  limit;
      bit  accept;
      bit  deliver;
      sent     = 0;
      received = 0;
      cycles   = 0;
      limit    = 20 * stim_q.size() + 50;
      while ((sent < stim_q.size() || received < stim_q.size()) && cycles < limit) begin
         if (stall_pct > 0) begin
            out_ready = ($unsigned($random(seed)) % 100) >= stall_pct;
         end else begin
            out_ready = 1'b1;
         end
         if (sent < stim_q.size()) begin
            in_valid = 1'b1;
            in_data  = stim_q[sent];
         end else begin
            in_valid = 1'b0;
         end
         // handshakes are settled a quarter period before the rising edge
         #1;
         accept  = in_valid && in_ready;
         deliver = out_valid && out_ready;
         @(negedge clk);
         if (accept) sent++;
         if (deliver) received++;
         cycles++;
      end
      in_valid  = 1'b0;
      out_ready = 1'b1;
      if (received < stim_q.size()) begin
         note_timeout("all results of a stream");
      end
      stim_q.delete();
   endtask

   task automatic finish_test(input string name);
      int n;
      n = (DUT.u_chk.fail_count - chk_mark) + (timeouts - timeout_mark);
      chk_mark     = DUT.u_chk.fail_count;
      timeout_mark = timeouts;
      tests_run++;
      total_fail += n;
      $display("test %-16s %0d failure(s)", name, n);
   endtask

   // ********************
   // tests
   // ********************
   task automatic apply_reset();
      int n;
      rst_n = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      n = 0;
      while (!in_ready && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (!in_ready) note_timeout("in_ready after reset");
   endtask

   task automatic sweep_single_weights();
      int w;
      int neg;
      int sh;
      int n3;
      int n2;
      for (w = 0; w < `NSPC_NUM_WEIGHT && timeouts == 0; w++) begin
         n3 = 1 + ($unsigned($random(seed)) % 8);
         n2 = 1 + ($unsigned($random(seed)) % 4);
         for (neg = 0; neg < 2; neg++) begin
            for (sh = 0; sh < 4; sh++) begin
               set_weight(w / `NSPC_NUM_IN, w % `NSPC_NUM_IN, neg != 0, n3, n2);
               set_shift(w / `NSPC_NUM_IN, (w % `NSPC_NUM_IN) / `NSPC_BUNDLE, sh);
               stim_q.push_back(32'h0000_0000);
               stim_q.push_back(32'h4444_4444);
               stim_q.push_back(32'h8888_8888);
               stim_q.push_back(32'hffff_ffff);
               stim_q.push_back(32'h048f_f840);
               stream_words(0);
            end
         end
         set_weight(w / `NSPC_NUM_IN, w % `NSPC_NUM_IN, 1'b0, 0, 0);
         set_shift(w / `NSPC_NUM_IN, (w % `NSPC_NUM_IN) / `NSPC_BUNDLE, 0);
      end
   endtask

   task automatic stream_reference_table(input int stall_pct);
      int i;
      load_table(REF_TABLE);
      set_shift(0, 0, 1);
      set_shift(0, 1, 2);
      set_shift(1, 0, 2);
      set_shift(1, 1, 2);
      // writes outside the map must change nothing
      cfg_write(20, 8'hff);
      cfg_write(31, 8'hff);
      for (i = 0; i < STREAM_LEN; i++) begin
         stim_q.push_back($random(seed));
      end
      stream_words(stall_pct);
   endtask

   task automatic drive_wrap_cases();
      int w;
      for (w = 0; w < `NSPC_NUM_WEIGHT; w++) begin
         set_weight(w / `NSPC_NUM_IN, w % `NSPC_NUM_IN, 1'b0, 8, 4);
      end
      for (w = 0; w < `NSPC_NUM_PE; w++) begin
         set_shift(w / `NSPC_NUM_BUNDLE, w % `NSPC_NUM_BUNDLE, 3);
      end
      stim_q.push_back(32'hffff_ffff);
      stim_q.push_back(32'hcccc_cccc);
      stream_words(0);
      // negative bundle in kernel 1
      for (w = 12; w < `NSPC_NUM_WEIGHT; w++) begin
         set_weight(1, w - `NSPC_NUM_IN, 1'b1, 7, 4);
      end
      stim_q.push_back(32'hffff_ffff);
      stim_q.push_back($random(seed));
      stream_words(0);
   endtask

   initial begin
      seed         = 32'hdd84_5d7e;
      clk          = 1'b0;
      rst_n        = 1'b0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b1;
      cfg_valid    = 1'b0;
      cfg_addr     = '0;
      cfg_data     = '0;
      timeouts     = 0;
      tests_run    = 0;
      total_fail   = 0;
      chk_mark     = 0;
      timeout_mark = 0;

      apply_reset();
      finish_test("reset");
      if (timeouts == 0) begin
         sweep_single_weights();
         finish_test("single_weights");
      end
      if (timeouts == 0) begin
         stream_reference_table(0);
         finish_test("reference_table");
      end
      if (timeouts == 0) begin
         stream_reference_table(45);
         finish_test("back_pressure");
      end
      if (timeouts == 0) begin
         drive_wrap_cases();
         finish_test("wrap_around");
      end

      $display("tests run %0d, failures %0d, timeouts %0d", tests_run, total_fail, timeouts);
      if (total_fail == 0 && timeouts == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* test/nspc_assertions.sv */
`timescale 1ns/1ps

`include "nspc_cfg.svh"

module nspc_assertions (
   input logic                                clk,
   input logic                                rst_n,
   input logic                                in_valid,
   input logic                                in_ready,
   input logic [`NSPC_NUM_IN*`NSPC_ACT_W-1:0] in_data,
   input logic                                out_valid,
   input logic                                out_ready,
   input logic [`NSPC_OUT_W-1:0]              out_y0,
   input logic [`NSPC_OUT_W-1:0]              out_y1,
   input logic                                cfg_valid,
   input logic [`NSPC_CFG_AW-1:0]             cfg_addr,
   input logic [7:0]                          cfg_data
);

   // mirrored configuration, decoded straight from the address map
   int m_sign [`NSPC_NUM_WEIGHT];
   int m_n3 [`NSPC_NUM_WEIGHT];
   int m_n2 [`NSPC_NUM_WEIGHT];
   int m_shift [`NSPC_NUM_PE];

   logic [2*`NSPC_OUT_W-1:0] exp_mem [8];
   logic [2:0]               wr_ptr;
   logic [2:0]               rd_ptr;
   int                       exp_count;
   int                       fail_count = 0;
   logic [`NSPC_OUT_W-1:0]   exp_y0;
   logic [`NSPC_OUT_W-1:0]   exp_y1;

   // ********************
   // reference model
   // ********************

   // each tap of bit 3 is worth 1, each tap of bit 2 is worth 1
   function automatic logic [`NSPC_OUT_W-1:0] expected_out(input logic [31:0] data,
                                                            input int k);
      int acc;
      int part;
      int term;
      int idx;
      int b;
      int j;
      logic [3:0] a;
      acc = 0;
      for (b = 0; b < `NSPC_NUM_BUNDLE; b++) begin
         part = 0;
         for (j = 0; j < `NSPC_BUNDLE; j++) begin
            idx  = b * `NSPC_BUNDLE + j;
            a    = data[31 - 4*idx -: 4];
            term = m_n3[k*`NSPC_NUM_IN + idx] * int'(a[3])
                 + m_n2[k*`NSPC_NUM_IN + idx] * int'(a[2]);
            if (m_sign[k*`NSPC_NUM_IN + idx] != 0) begin
               term = -term;
            end
            part = part + term;
         end
         acc = acc + part * (1 << m_shift[k*`NSPC_NUM_BUNDLE + b]);
      end
      return acc[`NSPC_OUT_W-1:0];
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_sign    <= '{default: 0};
         m_n3      <= '{default: 0};
         m_n2      <= '{default: 0};
         m_shift   <= '{default: 0};
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         exp_count <= 0;
      end else begin
         if (cfg_valid && cfg_addr < `NSPC_NUM_WEIGHT) begin
            m_sign[cfg_addr[3:0]] <= int'(cfg_data[7]);
            m_n3[cfg_addr[3:0]]   <= int'(cfg_data[6:3]);
            m_n2[cfg_addr[3:0]]   <= int'(cfg_data[2:0]);
         end else if (cfg_valid && cfg_addr >= `NSPC_SHIFT_BASE
                      && cfg_addr < `NSPC_SHIFT_BASE + `NSPC_NUM_PE) begin
            m_shift[cfg_addr[1:0]] <= int'(cfg_data[1:0]);
         end
         if (in_valid && in_ready) begin
            wr_ptr <= wr_ptr + 3'd1;
         end
         if (out_valid && out_ready) begin
            rd_ptr <= rd_ptr + 3'd1;
         end
         exp_count <= exp_count + int'(in_valid && in_ready) - int'(out_valid && out_ready);
      end
   end

   // expected results in acceptance order
   always_ff @(posedge clk) begin
      if (rst_n && in_valid && in_ready) begin
         exp_mem[wr_ptr] <= {expected_out(in_data, 0), expected_out(in_data, 1)};
      end
   end

   assign exp_y0 = exp_mem[rd_ptr][2*`NSPC_OUT_W-1:`NSPC_OUT_W];
   assign exp_y1 = exp_mem[rd_ptr][`NSPC_OUT_W-1:0];

   // ********************
   // checks
   // ********************
   a_y0_value: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out_ready && exp_count != 0 |-> out_y0 == exp_y0)
   else begin
      fail_count++;
      $error("CHECK FAILED time=%0t out_y0 got 0x%02h expected 0x%02h",
             $time, $sampled(out_y0), $sampled(exp_y0));
   end

   a_y1_value: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out_ready && exp_count != 0 |-> out_y1 == exp_y1)
   else begin
      fail_count++;
      $error("CHECK FAILED time=%0t out_y1 got 0x%02h expected 0x%02h",
             $time, $sampled(out_y1), $sampled(exp_y1));
   end

   a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && out_ready |-> exp_count != 0)
   else begin
      fail_count++;
      $error("an output was delivered with no accepted input outstanding at %0t", $time);
   end

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_y0) && $stable(out_y1))
   else begin
      fail_count++;
      $error("the output dropped or changed during a stall at %0t", $time);
   end

   // two items in flight with the output stalled means stage 1 is full
   a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready && exp_count >= 2 |-> !in_ready)
   else begin
      fail_count++;
      $error("in_ready stayed high with a full pipeline at %0t", $time);
   end

   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      $past(in_valid && in_ready, 2) && $past(out_ready) |-> out_valid)
   else begin
      fail_count++;
      $error("no result two edges after an accepted input at %0t", $time);
   end

   a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
   else begin
      fail_count++;
      $error("in_ready was low after reset release at %0t", $time);
   end

   a_idle_in_reset: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !out_valid)
   else begin
      fail_count++;
      $error("out_valid was high during or right after reset at %0t", $time);
   end

endmodule

/* src/nspc_top.sv */
`timescale 1ns/1ps

`include "nspc_cfg.svh"

module nspc_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              in_valid,
   output logic                              in_ready,
   input  logic [`NSPC_NUM_IN*`NSPC_ACT_W-1:0] in_data,
   output logic                              out_valid,
   input  logic                              out_ready,
   output nspc_pkg::sum_t                    out_y0,
   output nspc_pkg::sum_t                    out_y1,
   input  logic                              cfg_valid,
   input  logic [`NSPC_CFG_AW-1:0]           cfg_addr,
   input  nspc_pkg::cfg_word_u               cfg_data
);

   localparam int BUNDLE_BITS = `NSPC_BUNDLE * `NSPC_ACT_W;

   nspc_pkg::weight_code_t [`NSPC_NUM_WEIGHT-1:0]   weights;
   logic [`NSPC_NUM_PE-1:0][`NSPC_SHIFT_W-1:0]      shifts;
   nspc_pkg::sum_t [`NSPC_NUM_PE-1:0]               partials;
   logic                                            s1_load;

   // ********************
   // configuration
   // ********************
   nspc_weight_regs u_weight_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data),
      .weights   (weights),
      .shifts    (shifts)
   );

   // ********************
   // bundle PEs
   // ********************

   // bundle 0 takes the upper half of in_data
   for (genvar k = 0; k < `NSPC_NUM_OUT; k++) begin : g_kernel
      for (genvar b = 0; b < `NSPC_NUM_BUNDLE; b++) begin : g_bundle
         nspc_bundle_pe u_pe (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (s1_load),
            .acts    (in_data[(`NSPC_NUM_BUNDLE-1-b)*BUNDLE_BITS +: BUNDLE_BITS]),
            .weights (weights[k*`NSPC_NUM_IN + b*`NSPC_BUNDLE +: `NSPC_BUNDLE]),
            .shift   (shifts[k*`NSPC_NUM_BUNDLE + b]),
            .partial (partials[k*`NSPC_NUM_BUNDLE + b])
         );
      end
   end

   // ********************
   // kernel sums and handshake
   // ********************
   nspc_accum_stage u_accum_stage (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_ready  (in_ready),
      .s1_load   (s1_load),
      .partials  (partials),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_y0    (out_y0),
      .out_y1    (out_y1)
   );

endmodule

/* src/nspc_accum_stage.sv */
`timescale 1ns/1ps

`include "nspc_cfg.svh"

module nspc_accum_stage (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 in_valid,
   output logic                                 in_ready,
   output logic                                 s1_load,
   input  nspc_pkg::sum_t [`NSPC_NUM_PE-1:0]    partials,
   output logic                                 out_valid,
   input  logic                                 out_ready,
   output nspc_pkg::sum_t                       out_y0,
   output nspc_pkg::sum_t                       out_y1
);

   logic s1_valid;
   logic s2_load;

   // ********************
   // flow control
   // ********************

   // out_valid doubles as the stage 2 valid flag
   assign s2_load  = !out_valid || out_ready;
   assign s1_load  = !s1_valid || s2_load;
   assign in_ready = s1_load;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         if (s1_load) begin
            s1_valid <= in_valid;
         end
         if (s2_load) begin
            out_valid <= s1_valid;
         end
      end
   end

   // ********************
   // kernel sums
   // ********************

   // partials are ordered kernel 0 bundle 0, kernel 0 bundle 1, kernel 1 ...
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_y0 <= '0;
         out_y1 <= '0;
      end else if (s2_load && s1_valid) begin
         out_y0 <= partials[0] + partials[1];
         out_y1 <= partials[2] + partials[3];
      end
   end

endmodule

/* src/nspc_bundle_pe.sv */
`timescale 1ns/1ps

`include "nspc_cfg.svh"

module nspc_bundle_pe (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          load,
   input  logic [`NSPC_BUNDLE*`NSPC_ACT_W-1:0]           acts,
   input  nspc_pkg::weight_code_t [`NSPC_BUNDLE-1:0]     weights,
   input  logic [`NSPC_SHIFT_W-1:0]                      shift,
   output nspc_pkg::sum_t                                partial
);

   nspc_pkg::sum_t bundle_sum;

   // ********************
   // tap counting
   // ********************

   // masking the counts with the activation bit replaces the multiply
   function automatic nspc_pkg::sum_t tap_term(input nspc_pkg::act_t a,
                                               input nspc_pkg::weight_code_t w);
      nspc_pkg::sum_t taps3;
      nspc_pkg::sum_t taps2;
      nspc_pkg::sum_t mag;
      taps3 = nspc_pkg::sum_t'(w.n3 & {4{a[3]}});
      taps2 = nspc_pkg::sum_t'(w.n2 & {3{a[2]}});
      mag   = taps3 + taps2;
      return w.sign ? -mag : mag;
   endfunction

   // activation 0 of the bundle sits in the top nibble
   always_comb begin
      bundle_sum = '0;
      for (int j = 0; j < `NSPC_BUNDLE; j++) begin
         bundle_sum = bundle_sum
                    + tap_term(acts[(`NSPC_BUNDLE-1-j)*`NSPC_ACT_W +: `NSPC_ACT_W],
                               weights[j]);
      end
   end

   // ********************
   // stage 1 register
   // ********************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         partial <= '0;
      end else if (load) begin
         partial <= bundle_sum <<< shift;   // wraps at 8 bits
      end
   end

endmodule

/* src/nspc_weight_regs.sv */
`timescale 1ns/1ps

`include "nspc_cfg.svh"

module nspc_weight_regs (
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic                                              cfg_valid,
   input  logic [`NSPC_CFG_AW-1:0]                           cfg_addr,
   input  nspc_pkg::cfg_word_u                               cfg_data,
   output nspc_pkg::weight_code_t [`NSPC_NUM_WEIGHT-1:0]     weights,
   output logic [`NSPC_NUM_PE-1:0][`NSPC_SHIFT_W-1:0]        shifts
);

   localparam int WIDX_W = $clog2(`NSPC_NUM_WEIGHT);
   localparam int SIDX_W = $clog2(`NSPC_NUM_PE);

   logic                   weight_hit;
   logic                   shift_hit;
   logic [`NSPC_CFG_AW-1:0] shift_offset;

   // ********************
   // address decode
   // ********************
   assign shift_offset = cfg_addr - `NSPC_CFG_AW'(`NSPC_SHIFT_BASE);
   assign weight_hit   = cfg_valid && (cfg_addr < `NSPC_CFG_AW'(`NSPC_NUM_WEIGHT));
   assign shift_hit    = cfg_valid && (cfg_addr >= `NSPC_CFG_AW'(`NSPC_SHIFT_BASE))
                         && (shift_offset < `NSPC_CFG_AW'(`NSPC_NUM_PE));

   // weight codes, index is kernel * NUM_IN + input
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         weights <= '0;
      end else if (weight_hit) begin
         weights[cfg_addr[WIDX_W-1:0]] <= cfg_data.weight;
      end
   end

   // bundle shifts, index is kernel * NUM_BUNDLE + bundle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         shifts <= '0;
      end else if (shift_hit) begin
         // reserved bits of the shift view are not stored
         shifts[shift_offset[SIDX_W-1:0]] <= cfg_data.shift.amount;
      end
   end

endmodule

/* src/nspc_pkg.sv */
package nspc_pkg;

`include "nspc_cfg.svh"

   // one ReLU output, always non-negative
   typedef logic [`NSPC_ACT_W-1:0] act_t;

   // ********************
   // configuration word views
   // ********************

   // n3 counts copies of activation bit 3 (0..8), n2 copies of bit 2 (0..4)
   typedef struct packed {
      logic       sign;
      logic [3:0] n3;
      logic [2:0] n2;
   } weight_code_t;

   // only the low bits carry the bundle shift
   typedef struct packed {
      logic [7-`NSPC_SHIFT_W:0] rsvd;
      logic [`NSPC_SHIFT_W-1:0] amount;
   } shift_code_t;

   // address selects which view of cfg_data is stored
   typedef union packed {
      weight_code_t weight;
      shift_code_t  shift;
   } cfg_word_u;

   // partials and outputs wrap at this width
   typedef logic signed [`NSPC_OUT_W-1:0] sum_t;

endpackage

/* include/nspc_cfg.svh */
`ifndef NSPC_CFG_SVH
`define NSPC_CFG_SVH

// ********************
// datapath sizes
// ********************
`define NSPC_ACT_W     4
`define NSPC_NUM_IN    8
`define NSPC_BUNDLE    4
`define NSPC_NUM_OUT   2
`define NSPC_OUT_W     8

// bundles per kernel and total bundle PEs
`define NSPC_NUM_BUNDLE (`NSPC_NUM_IN / `NSPC_BUNDLE)
`define NSPC_NUM_PE     (`NSPC_NUM_OUT * `NSPC_NUM_BUNDLE)

// ********************
// configuration map
// ********************
`define NSPC_CFG_AW     5
`define NSPC_NUM_WEIGHT (`NSPC_NUM_OUT * `NSPC_NUM_IN)
`define NSPC_SHIFT_BASE 16
`define NSPC_SHIFT_W    2

`endif
